/* Makefile */
# Verilator build and run for the clkBoard testbench

VERILATOR ?= verilator
TOP       ?= clkBoardTb
FILELIST  ?= clkBoard.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line appears in the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* bench/clkBoardTb.sv */
/* Directed testbench for clkBoard. Inputs change on the falling edge and outputs are
   sampled just after it, while the DUT state is settled */
`timescale 1ns/10ps
`default_nettype none

module clkBoardTb
  import kl10BusPkg::*;
  import clkCtlPkg::*;
();

  localparam int BURST_WIDTH = 8;
  localparam int unsigned RAND_SEED = 32'h94bd_ec39;
  // Tests take at most about 600 cycles, limit at twice that
  localparam int CYCLE_LIMIT = 1200;

  logic     CLK;
  logic     arstN;
  logic     ctlFunc;
  logic     ldFunc;
  logic     diagRead;
  diagSelT  diagSel;
  loadDataT loadData;
  logic     eboxClkEn;
  logic     mrReset;
  diagDataT diagData;
  logic     diagDrive;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;

  // Expected configuration, updated by the load and control tasks
  logic [1:0] expSrc;
  logic [1:0] expRate;
  logic [2:0] expSect;
  logic [3:0] expPar;
  logic [3:0] expMisc;
  logic       expMrReset;

  clkBoard #(
    .BURST_WIDTH (BURST_WIDTH)
  ) u_clkBoard (
    .CLK       (CLK),
    .arstN     (arstN),
    .ctlFunc   (ctlFunc),
    .ldFunc    (ldFunc),
    .diagRead  (diagRead),
    .diagSel   (diagSel),
    .loadData  (loadData),
    .eboxClkEn (eboxClkEn),
    .mrReset   (mrReset),
    .diagData  (diagData),
    .diagDrive (diagDrive)
  );

  // 4 ns period
  always begin
    #2 CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic compareValue(input string sigName, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, sigName, actual, expected);
    end
  endtask

  // Readback word from the row layout and the expected state
  function automatic diagDataT modelRow(input int row, input logic [7:0] burstVal,
                                        input logic running, input logic bursting,
                                        input logic stepping);
    diagDataT value;
    case (row)
      0:       value = burstVal[7:2];
      1:       value = {burstVal[1:0], expRate, expSrc};
      2:       value = {expSect, expMrReset, running, bursting};
      3:       value = {expPar, stepping, 1'b0};
      4:       value = {expMisc, 2'b00};
      default: value = '0;
    endcase
    return value;
  endfunction

  // One-cycle control strobe, returns after the edge that takes it
  task automatic ctlStrobe(input diagSelT code);
    ctlFunc = 1'b1;
    diagSel = code;
    @(negedge CLK);
    ctlFunc = 1'b0;
    diagSel = '0;
    if (code == CTL_CLR_RESET) begin
      expMrReset = 1'b0;
    end
    if (code == CTL_SET_RESET) begin
      expMrReset = 1'b1;
    end
  endtask

  task automatic loadStrobe(input diagSelT code, input loadDataT data);
    ldFunc   = 1'b1;
    diagSel  = code;
    loadData = data;
    @(negedge CLK);
    ldFunc   = 1'b0;
    diagSel  = '0;
    loadData = '0;
    case (code)
      LD_SELECT:  {expSrc, expRate} = data;
      LD_DISABLE: expSect = data[2:0];
      LD_PAR_CHK: expPar = data;
      LD_MISC:    expMisc = data;
      default:    ;
    endcase
  endtask

  // Read a row for one cycle and compare it
  task automatic checkRow(input int row, input diagDataT expected);
    diagRead = 1'b1;
    diagSel  = diagSelT'(row);
    #1;
    compareValue("diagDrive", diagDrive, 1'b1);
    compareValue($sformatf("diagData row %0d", row), diagData, expected);
    @(negedge CLK);
    diagRead = 1'b0;
    diagSel  = '0;
  endtask

  task automatic countPulses(input int cycles, output int total);
    total = 0;
    repeat (cycles) begin
      if (eboxClkEn) begin
        total++;
      end
      @(negedge CLK);
    end
  endtask

  // Stops on the cycle that carries a pulse
  task automatic waitForPulse(input int limit, output int waited);
    waited = 0;
    while (eboxClkEn !== 1'b1 && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    if (eboxClkEn !== 1'b1) begin
      errorCount++;
      $display("Error at %0t: no EBOX clock pulse within %0d cycles", $time, limit);
    end
  endtask

  task automatic resetStateTest();
    int pulses;
    compareValue("mrReset", mrReset, 1'b1);
    compareValue("diagDrive", diagDrive, 1'b0);
    compareValue("diagData", diagData, 6'd0);
    countPulses(20, pulses);
    compareValue("eboxClkEn pulses", pulses, 0);
    for (int row = 0; row < 5; row++) begin
      checkRow(row, modelRow(row, 8'd0, 1'b0, 1'b0, 1'b0));
    end
  endtask

  task automatic configLoadTest();
    loadDataT data;
    repeat (4) begin
      for (int code = 4; code < 8; code++) begin
        data = loadDataT'($urandom);
        loadStrobe(diagSelT'(code), data);
      end
      // Rows 5 to 7 hold nothing
      for (int row = 1; row < 8; row++) begin
        checkRow(row, modelRow(row, 8'd0, 1'b0, 1'b0, 1'b0));
      end
    end
    // Back to rate 0 and source 0 for the later tests
    loadStrobe(LD_SELECT, 4'd0);
    checkRow(1, modelRow(1, 8'd0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic burstTest();
    logic [7:0] count;
    int pulses;
    int waited;
    int quiet;
    count = 8'(($urandom % 255) + 1);
    loadStrobe(LD_BURST_LO, count[3:0]);
    loadStrobe(LD_BURST_HI, count[7:4]);
    checkRow(0, modelRow(0, count, 1'b0, 1'b0, 1'b0));
    checkRow(1, modelRow(1, count, 1'b0, 1'b0, 1'b0));
    ctlStrobe(CTL_BURST);
    pulses = 0;
    waited = 0;
    // One pulse per cycle at rate 0, slack for latency
    while (pulses < count && waited < 2 * count + 8) begin
      if (eboxClkEn) begin
        pulses++;
      end
      @(negedge CLK);
      waited++;
    end
    compareValue("burst pulses", pulses, count);
    countPulses(50, quiet);
    compareValue("pulses after burst", quiet, 0);
    checkRow(0, modelRow(0, 8'd0, 1'b0, 1'b0, 1'b0));
    checkRow(1, modelRow(1, 8'd0, 1'b0, 1'b0, 1'b0));
    checkRow(2, modelRow(2, 8'd0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic runRateTest();
    int spacing;
    int waited;
    int quiet;
    for (int rate = 0; rate < 4; rate++) begin
      spacing = 1 << rate;
      loadStrobe(LD_SELECT, loadDataT'(rate));
      ctlStrobe(CTL_START);
      checkRow(2, modelRow(2, 8'd0, 1'b1, 1'b0, 1'b0));
      waitForPulse(spacing + 2, waited);
      // Gap between consecutive pulses
      repeat (2) begin
        @(negedge CLK);
        waitForPulse(spacing + 2, waited);
        compareValue($sformatf("pulse spacing at rate %0d", rate), waited + 1, spacing);
      end
      ctlStrobe(CTL_NONE);
      countPulses(4 * spacing + 4, quiet);
      compareValue("pulses after stop", quiet, 0);
      checkRow(2, modelRow(2, 8'd0, 1'b0, 1'b0, 1'b0));
    end
    loadStrobe(LD_SELECT, 4'd0);
  endtask

  task automatic singleStepTest();
    int waited;
    int quiet;
    // Step and EBOX step
    for (int code = 2; code < 4; code++) begin
      ctlStrobe(diagSelT'(code));
      waitForPulse(4, waited);
      @(negedge CLK);
      countPulses(20, quiet);
      compareValue($sformatf("extra pulses after step code %0d", code), quiet, 0);
      checkRow(3, modelRow(3, 8'd0, 1'b0, 1'b0, 1'b0));
    end
  endtask

  task automatic masterResetTest();
    ctlStrobe(CTL_CLR_RESET);
    compareValue("mrReset", mrReset, 1'b0);
    checkRow(2, modelRow(2, 8'd0, 1'b0, 1'b0, 1'b0));
    ctlStrobe(CTL_SET_RESET);
    compareValue("mrReset", mrReset, 1'b1);
    checkRow(2, modelRow(2, 8'd0, 1'b0, 1'b0, 1'b0));
  endtask

  initial begin
    CLK        = 1'b0;
    arstN      = 1'b0;
    ctlFunc    = 1'b0;
    ldFunc     = 1'b0;
    diagRead   = 1'b0;
    diagSel    = '0;
    loadData   = '0;
    expSrc     = '0;
    expRate    = '0;
    expSect    = '0;
    expPar     = '0;
    expMisc    = '0;
    expMrReset = 1'b1;
    void'($urandom(RAND_SEED));
    // Reset for 4 cycles
    repeat (4) @(negedge CLK);
    arstN = 1'b1;
    @(negedge CLK);
    resetStateTest();
    configLoadTest();
    burstTest();
    runRateTest();
    singleStepTest();
    masterResetTest();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* clkBoard.f */
logic/kl10BusPkg.sv
logic/clkCtlPkg.sv
logic/clkFuncDecode.sv
logic/eboxClockGate.sv
logic/clkDiagReadback.sv
logic/clkBoard.sv
bench/clkBoardTb.sv

/* logic/clkBoard.sv */
/* Single clock domain on CLK. BURST_WIDTH sets the burst counter and
   must be even, 4 to 8 */
`timescale 1ns/10ps
`default_nettype none

module clkBoard
  import kl10BusPkg::*;
  import clkCtlPkg::*;
#(
  parameter int BURST_WIDTH = 8
) (
  input  logic     CLK,
  input  logic     arstN,
  input  logic     ctlFunc,
  input  logic     ldFunc,
  input  logic     diagRead,
  input  diagSelT  diagSel,
  input  loadDataT loadData,
  output logic     eboxClkEn,
  output logic     mrReset,
  output diagDataT diagData,
  output logic     diagDrive
);

  // Decoder to gate
  logic startCmd;
  logic stepCmd;
  logic eboxStepCmd;
  logic burstCmd;
  logic stopCmd;
  logic loadBurstLo;
  logic loadBurstHi;
  rateSelT rateSel;

  // Stored state for readback
  srcSelT                 srcSel;
  sectDisT                sectDis;
  nibbleT                 parChk;
  nibbleT                 miscCfg;
  runModeE                runMode;
  logic [BURST_WIDTH-1:0] burstCount;
  logic                   stepPending;

  clkFuncDecode u_funcDecode (
    .CLK         (CLK),
    .arstN       (arstN),
    .ctlFunc     (ctlFunc),
    .ldFunc      (ldFunc),
    .diagSel     (diagSel),
    .loadData    (loadData),
    .startCmd    (startCmd),
    .stepCmd     (stepCmd),
    .eboxStepCmd (eboxStepCmd),
    .burstCmd    (burstCmd),
    .stopCmd     (stopCmd),
    .loadBurstLo (loadBurstLo),
    .loadBurstHi (loadBurstHi),
    .rateSel     (rateSel),
    .srcSel      (srcSel),
    .sectDis     (sectDis),
    .parChk      (parChk),
    .miscCfg     (miscCfg),
    .mrReset     (mrReset)
  );

  eboxClockGate #(
    .BURST_WIDTH (BURST_WIDTH)
  ) u_clockGate (
    .CLK         (CLK),
    .arstN       (arstN),
    .startCmd    (startCmd),
    .stepCmd     (stepCmd),
    .eboxStepCmd (eboxStepCmd),
    .burstCmd    (burstCmd),
    .stopCmd     (stopCmd),
    .loadBurstLo (loadBurstLo),
    .loadBurstHi (loadBurstHi),
    .loadData    (loadData),
    .rateSel     (rateSel),
    .eboxClkEn   (eboxClkEn),
    .runMode     (runMode),
    .burstCount  (burstCount),
    .stepPending (stepPending)
  );

  clkDiagReadback #(
    .BURST_WIDTH (BURST_WIDTH)
  ) u_readback (
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .burstCount  (burstCount),
    .rateSel     (rateSel),
    .srcSel      (srcSel),
    .sectDis     (sectDis),
    .parChk      (parChk),
    .miscCfg     (miscCfg),
    .mrReset     (mrReset),
    .runMode     (runMode),
    .stepPending (stepPending),
    .diagData    (diagData),
    .diagDrive   (diagDrive)
  );

endmodule

`default_nettype wire

/* logic/clkCtlPkg.sv */
/* Clock control codes and register shapes. Code 4 of the control functions
   (conditional single step) is not decoded and behaves like code 0 */
`default_nettype none

package clkCtlPkg;

  import kl10BusPkg::*;

  // Control functions (00x), carried on the select field
  typedef enum diagSelT {
    CTL_NONE      = 3'd0,
    CTL_START     = 3'd1,
    CTL_STEP      = 3'd2,
    CTL_EBOX_STEP = 3'd3,
    CTL_BURST     = 3'd5,
    CTL_CLR_RESET = 3'd6,
    CTL_SET_RESET = 3'd7
  } ctlFuncE;

  // Load functions (04x), codes 0 and 1 unused
  typedef enum diagSelT {
    LD_BURST_LO = 3'd2,
    LD_BURST_HI = 3'd3,
    LD_SELECT   = 3'd4,
    LD_DISABLE  = 3'd5,
    LD_PAR_CHK  = 3'd6,
    LD_MISC     = 3'd7
  } ldFuncE;

  // Readback rows, anything above row 4 reads zero
  localparam diagSelT ROW_BURST_HI = 3'd0;
  localparam diagSelT ROW_BURST_LO = 3'd1;
  localparam diagSelT ROW_SECT     = 3'd2;
  localparam diagSelT ROW_PAR_CHK  = 3'd3;
  localparam diagSelT ROW_MISC     = 3'd4;

  // EBOX gate state
  typedef enum logic [1:0] {
    MODE_STOPPED  = 2'd0,
    MODE_RUNNING  = 2'd1,
    MODE_BURSTING = 2'd2
  } runModeE;

  // Rate divider needs one bit per rate step, 2^3 at the slowest
  localparam int RATE_DIV_W = 3;

  typedef logic [1:0] rateSelT;
  typedef logic [1:0] srcSelT;
  // Full board width of the burst counter
  typedef logic [7:0] burstCountT;
  // CRM, EDP, CTL from high to low
  typedef logic [2:0] sectDisT;
  typedef logic [3:0] nibbleT;

endpackage

`default_nettype wire

/* logic/clkDiagReadback.sv */
/* Purely combinational; diagData is zero whenever diagRead is low.
   Burst count bits at or above BURST_WIDTH read as zero */
`timescale 1ns/10ps
`default_nettype none

module clkDiagReadback
  import kl10BusPkg::*;
  import clkCtlPkg::*;
#(
  parameter int BURST_WIDTH = 8
) (
  input  logic                   diagRead,
  input  diagSelT                diagSel,
  input  logic [BURST_WIDTH-1:0] burstCount,
  input  rateSelT                rateSel,
  input  srcSelT                 srcSel,
  input  sectDisT                sectDis,
  input  nibbleT                 parChk,
  input  nibbleT                 miscCfg,
  input  logic                   mrReset,
  input  runModeE                runMode,
  input  logic                   stepPending,
  output diagDataT               diagData,
  output logic                   diagDrive
);

  burstCountT burstPad;
  logic       running;
  logic       bursting;

  // Zero-extend to the board's 8-bit counter layout
  assign burstPad = burstCountT'(burstCount);
  assign running  = runMode == MODE_RUNNING;
  assign bursting = runMode == MODE_BURSTING;

  assign diagDrive = diagRead;

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        ROW_BURST_HI: diagData = burstPad[7:2];
        ROW_BURST_LO: diagData = {burstPad[1:0], rateSel, srcSel};
        ROW_SECT:     diagData = {sectDis, mrReset, running, bursting};
        ROW_PAR_CHK:  diagData = {parChk, stepPending, 1'b0};
        ROW_MISC:     diagData = {miscCfg, 2'b00};
        // Rows 5 to 7 unused
        default:      diagData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/clkFuncDecode.sv */
/* Function strobes are single cycle; at most one of ctlFunc and ldFunc per cycle.
   Config registers and mrReset change on the edge after the strobe */
`timescale 1ns/10ps
`default_nettype none

module clkFuncDecode
  import kl10BusPkg::*;
  import clkCtlPkg::*;
(
  input  logic     CLK,
  input  logic     arstN,
  input  logic     ctlFunc,
  input  logic     ldFunc,
  input  diagSelT  diagSel,
  input  loadDataT loadData,
  output logic     startCmd,
  output logic     stepCmd,
  output logic     eboxStepCmd,
  output logic     burstCmd,
  output logic     stopCmd,
  output logic     loadBurstLo,
  output logic     loadBurstHi,
  output rateSelT  rateSel,
  output srcSelT   srcSel,
  output sectDisT  sectDis,
  output nibbleT   parChk,
  output nibbleT   miscCfg,
  output logic     mrReset
);

  logic clrReset;
  logic setReset;
  logic loadSel;
  logic loadDis;
  logic loadPar;
  logic loadMisc;

  // Control function decoder
  // Every code reloads the gate, so the reset codes and 0/4 all count as stop
  always_comb begin
    startCmd    = 1'b0;
    stepCmd     = 1'b0;
    eboxStepCmd = 1'b0;
    burstCmd    = 1'b0;
    stopCmd     = 1'b0;
    clrReset    = 1'b0;
    setReset    = 1'b0;
    if (ctlFunc) begin
      case (diagSel)
        CTL_START:     startCmd = 1'b1;
        CTL_STEP:      stepCmd = 1'b1;
        CTL_EBOX_STEP: eboxStepCmd = 1'b1;
        CTL_BURST:     burstCmd = 1'b1;
        CTL_CLR_RESET: begin
          clrReset = 1'b1;
          stopCmd  = 1'b1;
        end
        CTL_SET_RESET: begin
          setReset = 1'b1;
          stopCmd  = 1'b1;
        end
        // None and the dropped conditional step
        default:       stopCmd = 1'b1;
      endcase
    end
  end

  // Load function decoder, codes 0 and 1 do nothing
  always_comb begin
    loadBurstLo = 1'b0;
    loadBurstHi = 1'b0;
    loadSel     = 1'b0;
    loadDis     = 1'b0;
    loadPar     = 1'b0;
    loadMisc    = 1'b0;
    if (ldFunc) begin
      case (diagSel)
        LD_BURST_LO: loadBurstLo = 1'b1;
        LD_BURST_HI: loadBurstHi = 1'b1;
        LD_SELECT:   loadSel = 1'b1;
        LD_DISABLE:  loadDis = 1'b1;
        LD_PAR_CHK:  loadPar = 1'b1;
        LD_MISC:     loadMisc = 1'b1;
        default:     ;
      endcase
    end
  end

  // Configuration registers
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      srcSel  <= '0;
      rateSel <= '0;
      sectDis <= '0;
      parChk  <= '0;
      miscCfg <= '0;
    end else begin
      // Source in the high pair, rate in the low pair
      if (loadSel) begin
        srcSel  <= loadData[3:2];
        rateSel <= loadData[1:0];
      end
      // Top data bit unused by the disables
      if (loadDis) begin
        sectDis <= loadData[2:0];
      end
      if (loadPar) begin
        parChk <= loadData;
      end
      if (loadMisc) begin
        miscCfg <= loadData;
      end
    end
  end

  // Master reset flip-flop, comes up asserted
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      mrReset <= 1'b1;
    end else if (clrReset) begin
      mrReset <= 1'b0;
    end else if (setReset) begin
      mrReset <= 1'b1;
    end
  end

  // At most one command or load strobe per cycle, lost if ctlFunc and ldFunc coincide
  cmdOneHot: assert property (@(posedge CLK) disable iff (!arstN)
    $onehot0({startCmd, stepCmd, eboxStepCmd, burstCmd, stopCmd,
              loadBurstLo, loadBurstHi, loadSel, loadDis, loadPar, loadMisc}));

endmodule

`default_nettype wire

/* logic/eboxClockGate.sv */
/* BURST_WIDTH must be even, 4 to 8. Command to first pulse takes up to 2^rateSel
   cycles since the rate divider free-runs */
`timescale 1ns/10ps
`default_nettype none

module eboxClockGate
  import kl10BusPkg::*;
  import clkCtlPkg::*;
#(
  parameter int BURST_WIDTH = 8
) (
  input  logic                   CLK,
  input  logic                   arstN,
  input  logic                   startCmd,
  input  logic                   stepCmd,
  input  logic                   eboxStepCmd,
  input  logic                   burstCmd,
  input  logic                   stopCmd,
  input  logic                   loadBurstLo,
  input  logic                   loadBurstHi,
  input  loadDataT               loadData,
  input  rateSelT                rateSel,
  output logic                   eboxClkEn,
  output runModeE                runMode,
  output logic [BURST_WIDTH-1:0] burstCount,
  output logic                   stepPending
);

  localparam logic [BURST_WIDTH-1:0] BURST_ONE = BURST_WIDTH'(1);

  logic [RATE_DIV_W-1:0] divCnt;
  logic [RATE_DIV_W-1:0] divMask;
  logic                  tick;
  logic                  anyCmd;
  logic                  burstPulse;
  burstCountT            burstLoad;

  // Free-running divider, tick when the low rateSel bits are all zero
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  assign divMask = ~({RATE_DIV_W{1'b1}} << rateSel);
  assign tick    = (divCnt & divMask) == '0;

  assign anyCmd = startCmd | stepCmd | eboxStepCmd | burstCmd | stopCmd;

  // One enable per tick while running, bursting with count left, or stepping
  assign eboxClkEn = tick & ((runMode == MODE_RUNNING) |
                             ((runMode == MODE_BURSTING) & (burstCount != '0)) |
                             stepPending);
  assign burstPulse = eboxClkEn & (runMode == MODE_BURSTING);

  // Run mode, any command reloads it
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      runMode <= MODE_STOPPED;
    end else if (anyCmd) begin
      if (startCmd) begin
        runMode <= MODE_RUNNING;
      end else if (burstCmd) begin
        runMode <= MODE_BURSTING;
      end else begin
        runMode <= MODE_STOPPED;
      end
    end else if (runMode == MODE_BURSTING) begin
      // Stop on the last pulse, or at once on an empty count
      if (burstCount == '0 || (burstPulse && burstCount == BURST_ONE)) begin
        runMode <= MODE_STOPPED;
      end
    end
  end

  // Single-step latch, cleared by its own pulse
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      stepPending <= 1'b0;
    end else if (anyCmd) begin
      stepPending <= stepCmd | eboxStepCmd;
    end else if (eboxClkEn) begin
      stepPending <= 1'b0;
    end
  end

  // Nibble loads go through a full-width copy so narrow counters drop the high part
  always_comb begin
    burstLoad = burstCountT'(burstCount);
    if (loadBurstLo) begin
      burstLoad[3:0] = loadData;
    end
    if (loadBurstHi) begin
      burstLoad[7:4] = loadData;
    end
  end

  // Burst counter, load wins over decrement
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      burstCount <= '0;
    end else if (loadBurstLo || loadBurstHi) begin
      burstCount <= burstLoad[BURST_WIDTH-1:0];
    end else if (burstPulse) begin
      burstCount <= burstCount - BURST_ONE;
    end
  end

  // A pending step only ever waits in the stopped mode
  stepWhenStopped: assert property (@(posedge CLK) disable iff (!arstN)
    stepPending |-> runMode == MODE_STOPPED);

  // An empty count stays empty until reloaded
  noUnderflow: assert property (@(posedge CLK) disable iff (!arstN)
    (burstCount == '0 && !loadBurstLo && !loadBurstHi) |=> burstCount == '0);

endmodule

`default_nettype wire

/* logic/kl10BusPkg.sv */
/* Diagnostic bus field shapes. Bit 0 of each vector is the least significant bit,
   so the board's data[35] maps to bit 0 here */
`default_nettype none

package kl10BusPkg;

  // Field widths on the diagnostic bus
  localparam int DIAG_SEL_W  = 3;
  localparam int LOAD_DATA_W = 4;
  localparam int DIAG_DATA_W = 6;

  // Function code or readback row number
  typedef logic [DIAG_SEL_W-1:0] diagSelT;

  // Data nibble written by a load function
  typedef logic [LOAD_DATA_W-1:0] loadDataT;

  // Readback word driven during a diagnostic read
  typedef logic [DIAG_DATA_W-1:0] diagDataT;

endpackage

`default_nettype wire
